/* src/seq_mult_pkg.sv */
// ======================================================================
// Shared definitions for the signed sequential multiplier
// Widths, request and response words, control FSM states
// ======================================================================
`default_nettype none

package seq_mult_pkg;

	// Operand width and product width
	localparam int DW = 16;
	localparam int DW_2 = 2 * DW;

	// Sweep counter must be able to hold the value DW itself
	localparam int CW = $clog2(DW + 1);

	// Counter value on which the sweep is complete
	localparam logic [CW-1:0] SWEEP_END = CW'(DW);

	// Operand pair presented with the start strobe
	typedef struct packed {
		logic signed [DW-1:0] multiplicand;
		logic signed [DW-1:0] multiplier;
	} mult_req_t;

	// Result word, valid for exactly one cycle
	typedef struct packed {
		logic result_valid;
		logic signed [DW_2-1:0] product;
	} mult_rsp_t;

	// States of the sequencing FSM
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SWEEP,
		FINISH
	} ctrl_state_t;

endpackage

`default_nettype wire

/* src/mult_control.sv */
// ======================================================================
// Control unit of the sequential multiplier
// Sequences load, sweep and finish, and reports busy
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module mult_control
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic done,
	output logic load,
	output logic permit,
	output logic capture,
	output logic busy
);

	// ==================================================================
	// State and start register
	// ==================================================================

	seq_mult_pkg::ctrl_state_t state;
	seq_mult_pkg::ctrl_state_t state_next;

	// Start is only taken while idle, so a strobe during an operation is lost
	logic start_q;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state <= seq_mult_pkg::IDLE;
			start_q <= 1'b0;
		end
		else
		begin
			state <= state_next;
			start_q <= start && (state == seq_mult_pkg::IDLE);
		end
	end

	// ==================================================================
	// Next state
	// ==================================================================

	always_comb
	begin
		state_next = state;
		case (state)
			seq_mult_pkg::IDLE:
			begin
				// A registered start moves the machine on one cycle later
				if (start_q)
				begin
					state_next = seq_mult_pkg::LOAD;
				end
			end
			seq_mult_pkg::LOAD:
			begin
				// The operand registers take their values on this edge
				state_next = seq_mult_pkg::SWEEP;
			end
			seq_mult_pkg::SWEEP:
			begin
				// Stay here until the adder has seen every multiplier bit
				if (done)
				begin
					state_next = seq_mult_pkg::FINISH;
				end
			end
			seq_mult_pkg::FINISH:
			begin
				// Returning to idle drops permit and clears the adder
				state_next = seq_mult_pkg::IDLE;
			end
			default:
			begin
				state_next = seq_mult_pkg::IDLE;
			end
		endcase
	end

	// ==================================================================
	// Outputs decoded from the state
	// ==================================================================

	assign load = (state == seq_mult_pkg::LOAD);

	// Permit stays up through finish so the adder holds its sum for capture
	assign permit = (state == seq_mult_pkg::SWEEP) || (state == seq_mult_pkg::FINISH);

	assign capture = (state == seq_mult_pkg::FINISH);

	// Busy also covers the cycle in which the accepted start is still registered
	assign busy = (state != seq_mult_pkg::IDLE) || start_q;

endmodule

`default_nettype wire

/* src/operand_prep.sv */
// ======================================================================
// Operand stage of the sequential multiplier
// Stores operand magnitudes and result sign, shifts the multiplicand
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module operand_prep
(
	input logic clk,
	input logic rst,
	input seq_mult_pkg::mult_req_t req,
	input logic load,
	input logic permit,
	output logic [seq_mult_pkg::DW-1:0] rgstr1,
	output logic [seq_mult_pkg::DW_2-1:0] rgstr2,
	output logic neg
);

	// ==================================================================
	// Magnitudes of the incoming operands
	// ==================================================================

	logic mcand_sign;
	logic mplier_sign;
	logic [seq_mult_pkg::DW-1:0] mcand_mag;
	logic [seq_mult_pkg::DW-1:0] mplier_mag;

	assign mcand_sign = req.multiplicand[seq_mult_pkg::DW-1];
	assign mplier_sign = req.multiplier[seq_mult_pkg::DW-1];

	// Two's complement of a negative operand taken as an unsigned value
	// The most negative operand maps onto the top bit alone, which still fits
	assign mcand_mag = mcand_sign ? (~req.multiplicand + 1'b1) : req.multiplicand;
	assign mplier_mag = mplier_sign ? (~req.multiplier + 1'b1) : req.multiplier;

	// ==================================================================
	// Result sign
	// ==================================================================

	// The result is negative when exactly one operand is negative
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			neg <= 1'b0;
		end
		else if (load)
		begin
			neg <= mcand_sign ^ mplier_sign;
		end
	end

	// ==================================================================
	// Operand registers
	// ==================================================================

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			// Multiplier magnitude is swept bit by bit by the adder
			rgstr1 <= mplier_mag;
			// Multiplicand is widened to the product width before shifting
			rgstr2 <= {{seq_mult_pkg::DW{1'b0}}, mcand_mag};
		end
		else if (permit)
		begin
			// One place per cycle keeps rgstr2 aligned with the bit the adder selects
			rgstr2 <= {rgstr2[seq_mult_pkg::DW_2-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* src/sweep_sequential_adder.sv */
// ======================================================================
// Shift-and-add accumulator of the sequential multiplier
// Sweeps the multiplier bits and sums the shifted multiplicand
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module sweep_sequential_adder
(
	input logic clk,
	input logic rst,
	input logic permit,
	input logic [seq_mult_pkg::DW-1:0] rgstr1,
	input logic [seq_mult_pkg::DW_2-1:0] rgstr2,
	output logic done,
	output logic [seq_mult_pkg::DW_2-1:0] product
);

	// Counter selects the multiplier bit that is examined in this cycle
	logic [seq_mult_pkg::CW-1:0] count;

	// Lower counter bits are enough to index the multiplier
	logic sel_bit;

	assign sel_bit = rgstr1[count[seq_mult_pkg::CW-2:0]];

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			count <= '0;
			product <= '0;
			done <= 1'b0;
		end
		else if (permit)
		begin
			if (count == seq_mult_pkg::SWEEP_END)
			begin
				// All bits seen, the sum is held here until permit drops
				done <= 1'b1;
			end
			else
			begin
				// rgstr2 already carries the weight of the selected bit
				if (sel_bit)
				begin
					product <= product + rgstr2;
				end
				count <= count + 1'b1;
			end
		end
		else
		begin
			// Without permit the accumulator is ready for the next operation
			count <= '0;
			product <= '0;
			done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/sign_restore.sv */
// ======================================================================
// Result stage of the sequential multiplier
// Applies the result sign and holds the signed product
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module sign_restore
(
	input logic clk,
	input logic rst,
	input logic capture,
	input logic neg,
	input logic [seq_mult_pkg::DW_2-1:0] product,
	output seq_mult_pkg::mult_rsp_t rsp
);

	// Magnitude with the result sign applied
	logic [seq_mult_pkg::DW_2-1:0] signed_product;

	// Negating zero gives zero again, so a zero product never turns negative
	assign signed_product = neg ? (~product + 1'b1) : product;

	// ==================================================================
	// Response register
	// ==================================================================

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			rsp.result_valid <= 1'b0;
			rsp.product <= '0;
		end
		else
		begin
			// Capture lasts one cycle, and so does the valid pulse behind it
			rsp.result_valid <= capture;

			// Product stays readable until the next capture
			if (capture)
			begin
				rsp.product <= signed_product;
			end
		end
	end

endmodule

`default_nettype wire

/* src/seq_mult_top.sv */
// ======================================================================
// Signed 16 by 16 sequential multiplier
// Control unit, operand stage, sweep adder and result stage
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module seq_mult_top
(
	input logic clk,
	input logic rst,
	input logic start,
	input seq_mult_pkg::mult_req_t req,
	output logic busy,
	output seq_mult_pkg::mult_rsp_t rsp
);

	// Control strobes and levels
	logic load;
	logic permit;
	logic capture;
	logic done;

	// Datapath between the stages
	logic [seq_mult_pkg::DW-1:0] rgstr1;
	logic [seq_mult_pkg::DW_2-1:0] rgstr2;
	logic [seq_mult_pkg::DW_2-1:0] product;
	logic neg;

	mult_control i_mult_control (
		.clk (clk),
		.rst (rst),
		.start (start),
		.done (done),
		.load (load),
		.permit (permit),
		.capture (capture),
		.busy (busy)
	);

	operand_prep i_operand_prep (
		.clk (clk),
		.rst (rst),
		.req (req),
		.load (load),
		.permit (permit),
		.rgstr1 (rgstr1),
		.rgstr2 (rgstr2),
		.neg (neg)
	);

	sweep_sequential_adder i_sweep_sequential_adder (
		.clk (clk),
		.rst (rst),
		.permit (permit),
		.rgstr1 (rgstr1),
		.rgstr2 (rgstr2),
		.done (done),
		.product (product)
	);

	sign_restore i_sign_restore (
		.clk (clk),
		.rst (rst),
		.capture (capture),
		.neg (neg),
		.product (product),
		.rsp (rsp)
	);

endmodule

`default_nettype wire

/* tb/seq_mult_sva.sv */
// ======================================================================
// Concurrent checks on the multiplier control unit
// Strobe widths, adder clear in idle, and done to capture timing
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module seq_mult_sva
(
	input logic clk,
	input logic rst,
	input seq_mult_pkg::ctrl_state_t state,
	input logic done,
	input logic load,
	input logic permit,
	input logic capture
);

	// Load and capture are single-cycle strobes
	a_load_pulse: assert property (@(posedge clk) disable iff (!rst) load |=> !load)
		else $error("load stayed high for more than one cycle");

	a_capture_pulse: assert property (@(posedge clk) disable iff (!rst) capture |=> !capture)
		else $error("capture stayed high for more than one cycle");

	// The adder is held cleared while no operation runs
	// A full cycle in IDLE without permit must have dropped done
	a_idle_clear: assert property (@(posedge clk) disable iff (!rst)
		(state == seq_mult_pkg::IDLE) && $past(state == seq_mult_pkg::IDLE) |-> !done)
		else $error("done still high after a full cycle in IDLE");

	// The FSM leaves the sweep on the cycle after done rises
	a_done_capture: assert property (@(posedge clk) disable iff (!rst) $rose(done) |=> capture)
		else $error("capture did not follow done on the next cycle");

endmodule

bind mult_control seq_mult_sva i_seq_mult_sva (
	.clk (clk),
	.rst (rst),
	.state (state),
	.done (done),
	.load (load),
	.permit (permit),
	.capture (capture)
);

`default_nettype wire

/* tb/seq_mult_tb.sv */
// ======================================================================
// Testbench for the signed sequential multiplier
// Runs the golden cases and checks product, latency, busy and reset
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module seq_mult_tb;

	localparam int CLK_PERIOD = 10;
	localparam int LATENCY = seq_mult_pkg::DW + 5;
	localparam int WAIT_LIMIT = seq_mult_pkg::DW + 10;
	localparam int CASE_BUDGET = seq_mult_pkg::DW + 12;
	localparam int WATCHDOG_MARGIN = 100;
	// Cycle after the start edge on which a second start is thrown in
	localparam int BUSY_START_AT = 6;

	// Case kinds with their own stimulus, as numbered in the golden file
	localparam int KIND_BUSY = 4;
	localparam int KIND_B2B = 5;
	localparam int KIND_RESET = 6;

	logic clk;
	logic rst;
	logic start;
	seq_mult_pkg::mult_req_t req;
	logic busy;
	seq_mult_pkg::mult_rsp_t rsp;

	// Golden cases, one entry per data line
	int kind_q[$];
	logic [seq_mult_pkg::DW-1:0] mcand_q[$];
	logic [seq_mult_pkg::DW-1:0] mplier_q[$];
	logic [seq_mult_pkg::DW_2-1:0] product_q[$];
	int n_cases;
	logic golden_loaded;
	int errors;
	int checks;

	// Product the result register has to show until the next valid pulse
	logic [seq_mult_pkg::DW_2-1:0] held_product;

	seq_mult_top i_seq_mult_top (
		.clk (clk),
		.rst (rst),
		.start (start),
		.req (req),
		.busy (busy),
		.rsp (rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// ==================================================================
	// Watchdog sized from the number of golden cases
	// ==================================================================

	initial
	begin
		wait (golden_loaded === 1'b1);
		repeat (n_cases * CASE_BUDGET + WATCHDOG_MARGIN)
		begin
			@(posedge clk);
		end
		$display("Watchdog expired at %0t ns, the run did not finish in time", $time);
		$display("Some tests failed");
		$finish;
	end

	// ==================================================================
	// Checks
	// ==================================================================

	task automatic check_value(input string name, input logic [seq_mult_pkg::DW_2-1:0] got,
		input logic [seq_mult_pkg::DW_2-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			$display("At %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	function automatic string kind_name(input int kind);
		case (kind)
			1: return "positive";
			2: return "signed";
			3: return "zero or one";
			4: return "start while busy";
			5: return "back-to-back";
			6: return "reset mid-sweep";
			default: return "unknown kind";
		endcase
	endfunction

	// ==================================================================
	// Stimulus
	// ==================================================================

	// Lines that do not hold four fields, the column header too, are skipped
	task automatic read_golden();
		int fd;
		int code;
		int kind;
		logic [seq_mult_pkg::DW-1:0] a;
		logic [seq_mult_pkg::DW-1:0] b;
		logic [seq_mult_pkg::DW_2-1:0] p;
		string line;
		fd = $fopen("tb/seq_mult_golden.txt", "r");
		if (fd == 0)
		begin
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && $sscanf(line, "%d %h %h %h", kind, a, b, p) == 4)
			begin
				kind_q.push_back(kind);
				mcand_q.push_back(a);
				mplier_q.push_back(b);
				product_q.push_back(p);
			end
		end
		$fclose(fd);
	endtask

	// Called on a falling edge, returns on the falling edge after the start edge
	task automatic start_op(input logic [seq_mult_pkg::DW-1:0] a,
		input logic [seq_mult_pkg::DW-1:0] b);
		req.multiplicand = a;
		req.multiplier = b;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Two quiet cycles between operations
	task automatic idle_gap();
		repeat (2)
		begin
			@(negedge clk);
			check_flag(!rsp.result_valid, "result_valid high outside its one-cycle pulse");
			check_flag(!busy, "busy high while no operation runs");
		end
	endtask

	// Counts cycles from the start edge until result_valid or the limit
	task automatic wait_result(input int inject_at, input logic check_held, output int cycles);
		cycles = 0;
		while (!rsp.result_valid && cycles < WAIT_LIMIT)
		begin
			check_flag(busy, "busy dropped before result_valid");
			if (check_held)
			begin
				check_value("rsp.product", rsp.product, held_product);
			end
			// A start thrown in mid-operation has to be dropped by the FSM
			start = (cycles == inject_at);
			@(negedge clk);
			cycles++;
		end
		start = 1'b0;
	endtask

	task automatic run_case(input int idx);
		int kind;
		int cycles;
		int errors_before;
		logic [seq_mult_pkg::DW-1:0] a;
		logic [seq_mult_pkg::DW-1:0] b;
		logic [seq_mult_pkg::DW_2-1:0] expected;
		kind = kind_q[idx];
		a = mcand_q[idx];
		b = mplier_q[idx];
		expected = product_q[idx];
		errors_before = errors;
		if (kind == KIND_B2B)
		begin
			// Start goes out while the previous result_valid is still high
			start_op(a, b);
			wait_result(-1, 1'b1, cycles);
		end
		else if (kind == KIND_RESET)
		begin
			idle_gap();
			start_op(a, b);
			repeat (8)
			begin
				@(negedge clk);
			end
			rst = 1'b0;
			@(negedge clk);
			check_flag(!busy, "busy not cleared by reset during the sweep");
			check_flag(!rsp.result_valid, "result_valid not cleared by reset");
			check_value("rsp.product", rsp.product, '0);
			rst = 1'b1;
			idle_gap();
			start_op(a, b);
			wait_result(-1, 1'b0, cycles);
		end
		else
		begin
			idle_gap();
			start_op(a, b);
			wait_result((kind == KIND_BUSY) ? BUSY_START_AT : -1, 1'b0, cycles);
		end
		if (rsp.result_valid)
		begin
			check_value("rsp.product", rsp.product, expected);
			check_count("latency", cycles, LATENCY);
			check_flag(!busy, "busy still high together with result_valid");
		end
		else
		begin
			check_flag(1'b0, $sformatf("no result_valid within %0d cycles of start", WAIT_LIMIT));
		end
		held_product = expected;
		if (kind == KIND_BUSY)
		begin
			// The dropped start would give its result within one latency
			repeat (LATENCY + 1)
			begin
				@(negedge clk);
				check_flag(!rsp.result_valid, "extra result_valid after a start while busy");
			end
		end
		$display("case %0d, %s: %h x %h = %h, latency %0d, %s", idx, kind_name(kind), a, b,
			expected, cycles, (errors == errors_before) ? "ok" : "FAILED");
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================

	initial
	begin
		rst = 1'b0;
		start = 1'b0;
		req = '0;
		errors = 0;
		checks = 0;
		held_product = '0;
		golden_loaded = 1'b0;
		read_golden();
		n_cases = kind_q.size();
		golden_loaded = 1'b1;
		check_flag(n_cases > 0, "golden file could not be read or holds no cases");
		repeat (2)
		begin
			@(negedge clk);
		end
		rst = 1'b1;
		@(negedge clk);
		check_flag(!busy, "busy high after reset");
		check_flag(!rsp.result_valid, "result_valid high after reset");
		check_value("rsp.product", rsp.product, '0);
		for (int i = 0; i < n_cases; i++)
		begin
			run_case(i);
		end
		$display("%0d cases, %0d checks, %0d errors", n_cases, checks, errors);
		if (errors == 0 && n_cases > 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* seq_mult.f */
src/seq_mult_pkg.sv
src/mult_control.sv
src/operand_prep.sv
src/sweep_sequential_adder.sv
src/sign_restore.sv
src/seq_mult_top.sv
tb/seq_mult_sva.sv
tb/seq_mult_tb.sv

/* Makefile */
# Verilator build and run of the signed sequential multiplier testbench

TOP := seq_mult_tb

.PHONY: help test clean

help:
	@echo "make help   show this list"
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f seq_mult.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* tb/seq_mult_golden.txt */
# kind multiplicand multiplier product, operands and product in hex
# kind 1 positive, 2 signed, 3 zero or one, 4 start while busy, 5 back-to-back, 6 reset
1 0003 0005 0000000F
1 0007 0009 0000003F
1 00FF 00FF 0000FE01
1 7FFF 7FFF 3FFF0001
1 1234 0010 00012340
1 0100 0100 00010000
1 7FFF 0002 0000FFFE
1 00C8 012C 0000EA60
1 0ABC 0DEF 00959184
2 FFFD 0005 FFFFFFF1
2 0007 FFF7 FFFFFFC1
2 FFF9 FFF7 0000003F
2 8000 0001 FFFF8000
2 8000 8000 40000000
2 8000 7FFF C0008000
2 8000 FFFF 00008000
2 FF38 012C FFFF15A0
2 FF38 FED4 0000EA60
2 8001 8001 3FFF0001
2 7FFF 8001 C000FFFF
2 EDCC 0010 FFFEDCC0
4 0019 0028 000003E8
3 0000 0000 00000000
3 0000 1234 00000000
3 8000 0000 00000000
3 0000 FFFF 00000000
3 1234 0001 00001234
3 0001 ABCD FFFFABCD
3 1234 FFFF FFFFEDCC
3 FFFF FFFF 00000001
3 7FFF FFFF FFFF8001
5 0006 0007 0000002A
5 FFFA 0007 FFFFFFD6
5 0100 FF00 FFFF0000
5 7FFF 7FFF 3FFF0001
6 0123 0456 0004EDC2
4 FF9C 0064 FFFFD8F0
6 8000 8000 40000000
